// File: logic/dvi_pkg.sv
package dvi_pkg;

    // Raster sizes in pixels and lines.
    localparam int H_ACTIVE = 32;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 6;
    localparam int H_BACK   = 6;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_ACTIVE = 8;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    localparam int H_CNT_W = $clog2(H_TOTAL);
    localparam int V_CNT_W = $clog2(V_TOTAL);

    localparam logic H_SYNC_POL = 1'b1;  // Active level.
    localparam logic V_SYNC_POL = 1'b1;

    localparam int TMDS_CHANNELS = 3;

    // Bit 0 goes out first.
    typedef logic [9:0] tmds_word_t;

    // Indexed by {c1,c0}.
    localparam tmds_word_t CTRL_CODE_00 = 10'b1101010100;
    localparam tmds_word_t CTRL_CODE_01 = 10'b0010101011;
    localparam tmds_word_t CTRL_CODE_10 = 10'b0101010100;
    localparam tmds_word_t CTRL_CODE_11 = 10'b1010101011;

    typedef struct packed {
        logic de;
        logic hsync;
        logic vsync;
    } video_ctrl_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_pixel_t;

endpackage

// File: logic/dvi_tx.sv
`timescale 1ns/1ps

module dvi_tx import dvi_pkg::*; (
    input  logic                     clk_i,
    input  logic                     clk_5x_i,
    input  logic                     rst_n_i,
    input  rgb_pixel_t               pixel_i,
    output logic                     pixel_req_o,
    output logic [TMDS_CHANNELS-1:0] tmds_o
);

    video_ctrl_t ctrl;
    logic [7:0]  component [TMDS_CHANNELS];
    logic [1:0]  ctrl_pair [TMDS_CHANNELS];
    tmds_word_t  symbol    [TMDS_CHANNELS];

    // Channel 0 is blue, 1 green, 2 red.
    assign component[0] = pixel_i.b;
    assign component[1] = pixel_i.g;
    assign component[2] = pixel_i.r;

    assign ctrl_pair[0] = {ctrl.vsync, ctrl.hsync};  // Sync rides on blue.
    assign ctrl_pair[1] = 2'b00;
    assign ctrl_pair[2] = 2'b00;

    video_timing i_timing (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ctrl_o      (ctrl),
        .pixel_req_o (pixel_req_o)
    );

    for (genvar ch = 0; ch < TMDS_CHANNELS; ch++) begin : g_channel
        tmds_encoder i_encoder (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .ctrl_i      (ctrl),
            .ctrl_pair_i (ctrl_pair[ch]),
            .data_i      (component[ch]),
            .symbol_o    (symbol[ch])
        );

        par2ser_10b i_serializer (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .clk_5x_i   (clk_5x_i),
            .par_data_i (symbol[ch]),
            .ser_data_o (tmds_o[ch])
        );
    end

endmodule

// File: logic/par2ser_10b.sv
`timescale 1ns/1ps

module par2ser_10b import dvi_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       clk_5x_i,
    input  tmds_word_t par_data_i,
    output logic       ser_data_o
);

    tmds_word_t word_q;
    logic       toggle_q;

    logic       toggle_seen_q;
    logic       restart;
    logic [2:0] phase_cur;
    logic [2:0] phase_q;
    tmds_word_t shadow_q;
    logic       even_d;
    logic       even_q;
    logic       odd_d;
    logic       odd_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            word_q   <= '0;
            toggle_q <= 1'b0;
        end else begin
            word_q   <= par_data_i;
            toggle_q <= ~toggle_q;  // Flips once per pixel clock.
        end
    end

    // First fast edge after a pixel clock edge.
    assign restart   = toggle_q ^ toggle_seen_q;
    assign phase_cur = restart ? 3'd1 : phase_q;

    // Phase 5 falls on the pixel clock edge and starts the new word.
    always_comb begin
        case (phase_cur)
            3'd1:    even_d = shadow_q[2];
            3'd2:    even_d = shadow_q[4];
            3'd3:    even_d = shadow_q[6];
            3'd4:    even_d = shadow_q[8];
            3'd5:    even_d = word_q[0];
            default: even_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk_5x_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            toggle_seen_q <= 1'b0;
            phase_q       <= '0;
            shadow_q      <= '0;
            even_q        <= 1'b0;
        end else begin
            toggle_seen_q <= toggle_q;
            phase_q       <= (phase_cur == 3'd5) ? 3'd1 : phase_cur + 3'd1;
            even_q        <= even_d;
            if (phase_cur == 3'd5) begin
                shadow_q <= word_q;
            end
        end
    end

    always_comb begin
        case (phase_q)
            3'd1:    odd_d = shadow_q[1];
            3'd2:    odd_d = shadow_q[3];
            3'd3:    odd_d = shadow_q[5];
            3'd4:    odd_d = shadow_q[7];
            3'd5:    odd_d = shadow_q[9];
            default: odd_d = 1'b0;
        endcase
    end

    always_ff @(negedge clk_5x_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            odd_q <= 1'b0;
        end else begin
            odd_q <= odd_d;
        end
    end

    assign ser_data_o = clk_5x_i ? even_q : odd_q;  // DDR output mux.

endmodule

// File: logic/tmds_encoder.sv
`timescale 1ns/1ps

module tmds_encoder import dvi_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  video_ctrl_t ctrl_i,
    input  logic [1:0]  ctrl_pair_i,
    input  logic [7:0]  data_i,
    output tmds_word_t  symbol_o
);

    logic [3:0]        data_ones;
    logic              use_xnor;
    logic [8:0]        q_m;

    logic [8:0]        q_m_q;
    logic              de_q;
    logic [1:0]        ctrl_pair_q;

    logic [3:0]        qm_ones;
    logic signed [5:0] qm_bal;
    logic signed [5:0] disp_q;
    logic signed [5:0] disp_d;
    tmds_word_t        symbol_d;

    always_comb begin
        data_ones = '0;
        for (int i = 0; i < 8; i++) begin
            data_ones = data_ones + 4'(data_i[i]);
        end
    end

    assign use_xnor = (data_ones > 4'd4) || ((data_ones == 4'd4) && !data_i[0]);

    // Bit 8 of the transition-minimised word flags the XOR form.
    always_comb begin
        q_m[0] = data_i[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data_i[i]) : (q_m[i-1] ^ data_i[i]);
        end
        q_m[8] = ~use_xnor;
    end

    always_ff @(posedge clk_i) begin
        q_m_q <= q_m;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_q        <= 1'b0;
            ctrl_pair_q <= 2'b00;
        end else begin
            de_q        <= ctrl_i.de;
            ctrl_pair_q <= ctrl_pair_i;
        end
    end

    always_comb begin
        qm_ones = '0;
        for (int i = 0; i < 8; i++) begin
            qm_ones = qm_ones + 4'(q_m_q[i]);
        end
    end

    assign qm_bal = $signed({1'b0, qm_ones, 1'b0}) - 6'sd8;  // Ones minus zeros.

    always_comb begin
        symbol_d = CTRL_CODE_00;
        disp_d   = '0;
        if (!de_q) begin
            case (ctrl_pair_q)
                2'b01:   symbol_d = CTRL_CODE_01;
                2'b10:   symbol_d = CTRL_CODE_10;
                2'b11:   symbol_d = CTRL_CODE_11;
                default: symbol_d = CTRL_CODE_00;
            endcase
        end else if ((disp_q == 0) || (qm_bal == 0)) begin
            symbol_d = {~q_m_q[8], q_m_q[8], q_m_q[8] ? q_m_q[7:0] : ~q_m_q[7:0]};
            disp_d   = q_m_q[8] ? (disp_q + qm_bal) : (disp_q - qm_bal);
        end else if ((disp_q > 0) == (qm_bal > 0)) begin
            // Disparity would grow further, so invert.
            symbol_d = {1'b1, q_m_q[8], ~q_m_q[7:0]};
            disp_d   = disp_q - qm_bal + (q_m_q[8] ? 6'sd2 : 6'sd0);
        end else begin
            symbol_d = {1'b0, q_m_q[8], q_m_q[7:0]};
            disp_d   = disp_q + qm_bal - (q_m_q[8] ? 6'sd0 : 6'sd2);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            symbol_o <= CTRL_CODE_00;
            disp_q   <= '0;
        end else begin
            symbol_o <= symbol_d;
            disp_q   <= disp_d;
        end
    end

endmodule

// File: logic/video_timing.sv
`timescale 1ns/1ps

module video_timing import dvi_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    output video_ctrl_t ctrl_o,
    output logic        pixel_req_o
);

    logic [H_CNT_W-1:0] h_cnt_q;
    logic [V_CNT_W-1:0] v_cnt_q;
    logic               h_last;
    logic               v_last;
    logic               h_active;
    logic               v_active;
    logic               h_sync_win;
    logic               v_sync_win;
    video_ctrl_t        ctrl_d;

    assign h_last = (h_cnt_q == H_CNT_W'(H_TOTAL - 1));
    assign v_last = (v_cnt_q == V_CNT_W'(V_TOTAL - 1));

    // Position (0,0) is the first active pixel.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt_q <= '0;
            v_cnt_q <= '0;
        end else if (h_last) begin
            h_cnt_q <= '0;
            if (v_last) begin
                v_cnt_q <= '0;
            end else begin
                v_cnt_q <= v_cnt_q + 1'b1;
            end
        end else begin
            h_cnt_q <= h_cnt_q + 1'b1;
        end
    end

    assign h_active = (h_cnt_q < H_CNT_W'(H_ACTIVE));
    assign v_active = (v_cnt_q < V_CNT_W'(V_ACTIVE));

    assign h_sync_win = (h_cnt_q >= H_CNT_W'(H_SYNC_START)) &&
                        (h_cnt_q <  H_CNT_W'(H_SYNC_END));
    assign v_sync_win = (v_cnt_q >= V_CNT_W'(V_SYNC_START)) &&
                        (v_cnt_q <  V_CNT_W'(V_SYNC_END));

    always_comb begin
        ctrl_d.de    = h_active && v_active;
        ctrl_d.hsync = h_sync_win ? H_SYNC_POL : ~H_SYNC_POL;
        ctrl_d.vsync = v_sync_win ? V_SYNC_POL : ~V_SYNC_POL;  // Held for whole lines.
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_o.de    <= 1'b0;
            ctrl_o.hsync <= ~H_SYNC_POL;
            ctrl_o.vsync <= ~V_SYNC_POL;
        end else begin
            ctrl_o <= ctrl_d;
        end
    end

    assign pixel_req_o = ctrl_o.de;

endmodule

// File: run.sh
#!/bin/sh
# Builds and runs the DVI transmitter testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_dvi_tx -Mdir obj_dir -o vsim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Everything OK" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0

// File: tb.f
+incdir+verification
logic/dvi_pkg.sv
logic/video_timing.sv
logic/tmds_encoder.sv
logic/par2ser_10b.sv
logic/dvi_tx.sv
verification/tb_dvi_tx.sv

// File: verification/tmds_model.svh
function automatic tmds_word_t ctrl_symbol(input logic [1:0] pair);
    case (pair)
        2'b01:   return CTRL_CODE_01;
        2'b10:   return CTRL_CODE_10;
        2'b11:   return CTRL_CODE_11;
        default: return CTRL_CODE_00;
    endcase
endfunction

// Encodes one symbol and advances the running disparity.
function automatic tmds_word_t model_encode(input logic de, input logic [1:0] pair,
                                            input logic [7:0] data, inout int disp);
    int         n1;
    int         n1q;
    logic       xnor_sel;
    logic [8:0] qm;
    tmds_word_t word;
    if (!de) begin
        disp = 0;
        return ctrl_symbol(pair);
    end
    n1       = $countones(data);
    xnor_sel = (n1 > 4) || ((n1 == 4) && !data[0]);
    qm[0]    = data[0];
    for (int i = 1; i < 8; i++) begin
        qm[i] = xnor_sel ? ~(qm[i-1] ^ data[i]) : (qm[i-1] ^ data[i]);
    end
    qm[8] = !xnor_sel;
    n1q   = $countones(qm[7:0]);
    if ((disp == 0) || (n1q == 4)) begin
        word = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
        disp = qm[8] ? (disp + 2 * n1q - 8) : (disp + 8 - 2 * n1q);
    end else if (((disp > 0) && (n1q > 4)) || ((disp < 0) && (n1q < 4))) begin
        word = {1'b1, qm[8], ~qm[7:0]};
        disp = disp + (qm[8] ? 2 : 0) + 8 - 2 * n1q;
    end else begin
        word = {1'b0, qm[8], qm[7:0]};
        disp = disp - (qm[8] ? 0 : 2) + 2 * n1q - 8;
    end
    return word;
endfunction

function automatic logic [7:0] model_decode(input tmds_word_t w);
    logic [7:0] d;
    logic [7:0] q;
    d    = w[9] ? ~w[7:0] : w[7:0];
    q[0] = d[0];
    for (int i = 1; i < 8; i++) begin
        q[i] = w[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return q;
endfunction

// Ones minus zeros of a whole symbol.
function automatic int word_balance(input tmds_word_t w);
    return 2 * $countones(w) - 10;
endfunction

// File: verification/tb_dvi_tx.sv
`timescale 1ns/1ps

module tb_dvi_tx import dvi_pkg::*; ();

    `include "tmds_model.svh"

    localparam logic [31:0] SEED        = 32'h85eb1366;
    localparam int          FRAMES      = 3;
    localparam int          HIST        = 4096;
    localparam longint      WATCHDOG_NS = longint'(FRAMES + 1) * H_TOTAL * V_TOTAL * 100 + 20000;

    logic                     clk_i    = 1'b0;
    logic                     clk_5x_i = 1'b0;
    logic                     rst_n_i;
    rgb_pixel_t               pixel_i;
    logic                     pixel_req_o;
    logic [TMDS_CHANNELS-1:0] tmds_o;

    logic [31:0] lfsr_state = SEED;
    video_ctrl_t hist_ctrl [HIST];
    rgb_pixel_t  hist_pix  [HIST];
    video_ctrl_t m_ctrl = '0;
    int          m_h = -1;
    int          m_v = -1;
    int          cnt_h = 0;
    int          cnt_v = 0;
    int          edge_cnt = 0;
    int          req_count = 0;
    logic        req_prev = 1'b0;
    int          frames_done = 0;
    int          win;
    tmds_word_t  rx_sym [TMDS_CHANNELS];
    int          disp_model [TMDS_CHANNELS] = '{0, 0, 0};
    int          bal_acc [TMDS_CHANNELS] = '{0, 0, 0};
    int          chk [5] = '{0, 0, 0, 0, 0};
    int          err [5] = '{0, 0, 0, 0, 0};
    string       test_name [5] = '{"blanking_symbols", "raster_timing", "data_round_trip",
                                   "exact_encoding", "dc_balance"};

    dvi_tx i_dut (
        .clk_i       (clk_i),
        .clk_5x_i    (clk_5x_i),
        .rst_n_i     (rst_n_i),
        .pixel_i     (pixel_i),
        .pixel_req_o (pixel_req_o),
        .tmds_o      (tmds_o)
    );

    always #50 clk_i = ~clk_i;
    always #10 clk_5x_i = ~clk_5x_i;  // Rising edges line up with clk_i.

    function automatic logic next_random_bit();
        logic b;
        b          = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return b;
    endfunction

    function automatic rgb_pixel_t random_pixel();
        logic [23:0] v;
        for (int i = 0; i < 24; i++) begin
            v[i] = next_random_bit();
        end
        return rgb_pixel_t'(v);
    endfunction

    function automatic video_ctrl_t raster_ctrl(input int h, input int v);
        video_ctrl_t c;
        c.de    = (h < H_ACTIVE) && (v < V_ACTIVE);
        c.hsync = ((h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC)) ?
                  H_SYNC_POL : ~H_SYNC_POL;
        c.vsync = ((v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC)) ?
                  V_SYNC_POL : ~V_SYNC_POL;
        return c;
    endfunction

    task automatic record_check(input int test, input logic cond, input string msg);
        chk[test]++;
        assert (cond) else begin
            $display("[ERROR] %0t ns: %s", $time, msg);
            err[test]++;
        end
    endtask

    // Compares the symbols that started at edge m with the model.
    task automatic check_window(input int m);
        video_ctrl_t c;
        rgb_pixel_t  p;
        logic [7:0]  comp;
        logic [1:0]  pair;
        tmds_word_t  exp_sym;
        c = hist_ctrl[(m > 3) ? (m - 3) : 0];  // Index 0 holds the reset state.
        p = hist_pix[(m > 3) ? (m - 3) : 0];
        for (int ch = 0; ch < TMDS_CHANNELS; ch++) begin
            comp    = (ch == 0) ? p.b : ((ch == 1) ? p.g : p.r);
            pair    = (ch == 0) ? {c.vsync, c.hsync} : 2'b00;
            exp_sym = model_encode(c.de, pair, comp, disp_model[ch]);
            if (!c.de) begin
                record_check(0, rx_sym[ch] == exp_sym, $sformatf(
                    "ch%0d blanking symbol %h, expected %h", ch, rx_sym[ch], exp_sym));
                if ((ch == 0) && (pair != 2'b00)) begin
                    record_check(1, rx_sym[ch] == exp_sym, $sformatf(
                        "blue sync symbol %h, expected %h", rx_sym[ch], exp_sym));
                end
                bal_acc[ch] = 0;  // Blanking clears the disparity.
            end else begin
                record_check(2, model_decode(rx_sym[ch]) == comp, $sformatf(
                    "ch%0d decoded %h, sent %h", ch, model_decode(rx_sym[ch]), comp));
                record_check(3, rx_sym[ch] == exp_sym, $sformatf(
                    "ch%0d symbol %h, expected %h", ch, rx_sym[ch], exp_sym));
                bal_acc[ch] = bal_acc[ch] + word_balance(rx_sym[ch]);
                record_check(4, (bal_acc[ch] == disp_model[ch]) &&
                             (bal_acc[ch] <= 10) && (bal_acc[ch] >= -10), $sformatf(
                    "ch%0d balance %0d, model %0d", ch, bal_acc[ch], disp_model[ch]));
            end
        end
    endtask

    // Model raster steps once per pixel clock after reset.
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            m_ctrl = raster_ctrl(cnt_h, cnt_v);
            m_h    = cnt_h;
            m_v    = cnt_v;
            if (cnt_h == H_TOTAL - 1) begin
                cnt_h = 0;
                cnt_v = (cnt_v == V_TOTAL - 1) ? 0 : cnt_v + 1;
            end else begin
                cnt_h++;
            end
            edge_cnt++;
        end
    end

    always @(negedge clk_i) begin
        pixel_i = random_pixel();
        hist_ctrl[edge_cnt+1] = m_ctrl;  // Seen by the DUT at the next edge.
        hist_pix[edge_cnt+1]  = pixel_i;
        record_check(1, pixel_req_o == m_ctrl.de, $sformatf(
            "pixel_req_o %b at (%0d,%0d)", pixel_req_o, m_h, m_v));
        if (m_ctrl.de && (m_h == 0) && (m_v == 0) && (req_count > 0)) begin
            record_check(1, req_count == H_ACTIVE * V_ACTIVE, $sformatf(
                "%0d pixel requests in a frame", req_count));
            frames_done++;
            req_count = 0;
        end
        if (pixel_req_o && !req_prev) begin
            record_check(1, m_h == 0, $sformatf("request run started at column %0d", m_h));
        end
        if (pixel_req_o) begin
            req_count++;
        end
        req_prev = pixel_req_o;
    end

    // Samples each serial bit in the middle of its half period.
    initial begin
        wait (rst_n_i);
        @(posedge clk_i);
        win = 1;
        forever begin
            for (int k = 0; k < 10; k++) begin
                #5;
                for (int ch = 0; ch < TMDS_CHANNELS; ch++) begin
                    rx_sym[ch][k] = tmds_o[ch];
                end
                #5;
            end
            if (win == 1) begin
                for (int ch = 0; ch < TMDS_CHANNELS; ch++) begin
                    record_check(0, rx_sym[ch] == '0, $sformatf(
                        "ch%0d sent %h before the first capture", ch, rx_sym[ch]));
                end
            end else begin
                check_window(win);
            end
            win++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all frames were checked");
        $display("Something failed");
        $finish;
    end

    initial begin
        int total_chk;
        int total_err;
        total_chk = 0;
        total_err = 0;
        for (int i = 0; i < HIST; i++) begin
            hist_ctrl[i] = '0;
            hist_pix[i]  = '0;
        end
        rst_n_i = 1'b0;
        pixel_i = '0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        wait (frames_done >= FRAMES);
        repeat (6) @(posedge clk_i);  // Drain the pipeline.
        for (int t = 0; t < 5; t++) begin
            $display("%-18s %0d checks, %0d errors", test_name[t], chk[t], err[t]);
            total_chk += chk[t];
            total_err += err[t];
        end
        $display("Totals: %0d checks, %0d errors", total_chk, total_err);
        if (total_err == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
